// ==== verilog/jtframe_romload_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM download path shared definitions
// Widths of the I/O controller stream and of the
// SDRAM programming port, plus the writer states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package jtframe_romload_pkg;

    // SDRAM word address width
    localparam int sdramw = 22;

    // I/O controller side
    typedef logic [24:0] ioctl_addr_t;
    typedef logic [ 7:0] ioctl_data_t;

    // SDRAM programming side
    typedef logic [sdramw-1:0] prog_addr_t;
    typedef logic [      15:0] prog_data_t;
    // Set bit means that byte lane is left untouched
    typedef logic [       1:0] prog_mask_t;
    typedef logic [       1:0] prog_ba_t;

    // Programming port writer
    typedef enum logic {
        wr_idle,
        wr_hold
    } wr_state_t;

endpackage

`default_nettype wire

// ==== verilog/jtframe_prog_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One queued SDRAM write with valid/ready
// Transfer on a clock edge with both high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

interface jtframe_prog_if import jtframe_romload_pkg::*; ();

    prog_addr_t addr;
    prog_data_t data;
    prog_mask_t mask;
    prog_ba_t   ba;
    logic       valid;
    logic       ready;

    // Side that offers entries
    modport src (
        output addr,
        output data,
        output mask,
        output ba,
        output valid,
        input  ready
    );

    // Side that accepts entries
    modport dst (
        input  addr,
        input  data,
        input  mask,
        input  ba,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// ==== verilog/jtframe_dwnld_pack.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Download byte packer
// Skips the file header, picks the SDRAM bank by
// offset and turns each byte into a masked word
// write. Flags bytes lost to back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module jtframe_dwnld_pack import jtframe_romload_pkg::*; #(
    parameter int header    = 0,
    parameter int ba1_start = 'h100,
    parameter int ba2_start = 'h200,
    parameter int ba3_start = 'h300
)(
    input  logic           clk_rom,
    input  logic           rst_n,
    input  logic           downloading,
    input  ioctl_addr_t    ioctl_addr,
    input  ioctl_data_t    ioctl_data,
    input  logic           ioctl_wr,
    jtframe_prog_if.src    q,
    output logic           ovf
);

    logic        dl_last;
    logic        in_file;
    ioctl_addr_t offset;
    ioctl_addr_t bank_start;
    ioctl_addr_t rel;
    prog_ba_t    bank;

    // Offset into the file past the header
    always_comb begin
        in_file = ioctl_addr >= ioctl_addr_t'(header);
        offset  = ioctl_addr - ioctl_addr_t'(header);
        // Highest bank whose start is not above the offset
        if (offset >= ioctl_addr_t'(ba3_start)) begin
            bank       = 2'd3;
            bank_start = ioctl_addr_t'(ba3_start);
        end else if (offset >= ioctl_addr_t'(ba2_start)) begin
            bank       = 2'd2;
            bank_start = ioctl_addr_t'(ba2_start);
        end else if (offset >= ioctl_addr_t'(ba1_start)) begin
            bank       = 2'd1;
            bank_start = ioctl_addr_t'(ba1_start);
        end else begin
            bank       = 2'd0;
            bank_start = '0;
        end
        rel = offset - bank_start;
    end

    // Control and overflow flag
    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            dl_last <= 1'b0;
            q.valid <= 1'b0;
            ovf     <= 1'b0;
        end else begin
            dl_last <= downloading;
            // One cycle offer per accepted byte
            q.valid <= downloading && ioctl_wr && in_file;
            if (downloading && !dl_last) begin
                ovf <= 1'b0;
            end else if (q.valid && !q.ready) begin
                ovf <= 1'b1;
            end
        end
    end

    // Word write built from the byte
    always_ff @(posedge clk_rom) begin
        if (ioctl_wr) begin
            q.addr <= rel[sdramw:1];
            q.data <= {ioctl_data, ioctl_data};
            // Bank starts are even, so rel keeps the byte lane
            q.mask <= rel[0] ? 2'b01 : 2'b10;
            q.ba   <= bank;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/jtframe_prog_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Show-ahead FIFO of queued SDRAM writes
// Circular buffer, pointers one bit wider than
// the index to tell full from empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module jtframe_prog_fifo import jtframe_romload_pkg::*; #(
    parameter int fifo_depth = 4
)(
    input  logic        clk_rom,
    input  logic        rst_n,
    jtframe_prog_if.dst wr,
    jtframe_prog_if.src rd,
    output logic        empty
);

    localparam int aw = $clog2(fifo_depth);

    prog_addr_t  addr_mem [fifo_depth];
    prog_data_t  data_mem [fifo_depth];
    prog_mask_t  mask_mem [fifo_depth];
    prog_ba_t    ba_mem   [fifo_depth];

    logic [aw:0] wr_ptr;
    logic [aw:0] rd_ptr;
    logic        full;
    logic        push;
    logic        pop;

    // Same index, different wrap bit
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign empty = wr_ptr == rd_ptr;

    // A pop frees the slot the push needs
    assign wr.ready = !full || rd.ready;
    assign push     = wr.valid && wr.ready;
    assign pop      = rd.valid && rd.ready;

    // Head entry presented directly
    assign rd.valid = !empty;
    assign rd.addr  = addr_mem[rd_ptr[aw-1:0]];
    assign rd.data  = data_mem[rd_ptr[aw-1:0]];
    assign rd.mask  = mask_mem[rd_ptr[aw-1:0]];
    assign rd.ba    = ba_mem[rd_ptr[aw-1:0]];

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'd1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_rom) begin
        if (push) begin
            addr_mem[wr_ptr[aw-1:0]] <= wr.addr;
            data_mem[wr_ptr[aw-1:0]] <= wr.data;
            mask_mem[wr_ptr[aw-1:0]] <= wr.mask;
            ba_mem[wr_ptr[aw-1:0]]   <= wr.ba;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/jtframe_prog_wr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM programming port writer
// Takes one queued write at a time and holds
// prog_we until the controller answers prog_rdy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module jtframe_prog_wr import jtframe_romload_pkg::*; (
    input  logic        clk_rom,
    input  logic        rst_n,
    jtframe_prog_if.dst q,
    output prog_addr_t  prog_addr,
    output prog_data_t  prog_data,
    output prog_mask_t  prog_mask,
    output prog_ba_t    prog_ba,
    output logic        prog_we,
    input  logic        prog_rdy,
    output logic        idle
);

    wr_state_t state;

    // Only one write in flight
    assign q.ready = state == wr_idle;
    assign idle    = state == wr_idle;

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            state   <= wr_idle;
            prog_we <= 1'b0;
        end else begin
            case (state)
                wr_idle: begin
                    if (q.valid) begin
                        state   <= wr_hold;
                        prog_we <= 1'b1;
                    end
                end
                wr_hold: begin
                    // Controller acknowledge ends the write
                    if (prog_rdy) begin
                        state   <= wr_idle;
                        prog_we <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Address, data and mask stay put while prog_we is high
    always_ff @(posedge clk_rom) begin
        if (q.valid && q.ready) begin
            prog_addr <= q.addr;
            prog_data <= q.data;
            prog_mask <= q.mask;
            prog_ba   <= q.ba;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/jtframe_romload.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM download path
// I/O controller byte stream to SDRAM programming
// port, through packer, FIFO and writer. Reports
// loading busy and lost bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module jtframe_romload import jtframe_romload_pkg::*; #(
    parameter int header     = 0,
    parameter int ba1_start  = 'h100,
    parameter int ba2_start  = 'h200,
    parameter int ba3_start  = 'h300,
    parameter int fifo_depth = 4
)(
    input  logic        clk_rom,
    input  logic        rst_n,
    // I/O controller download
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  ioctl_data_t ioctl_data,
    input  logic        ioctl_wr,
    // SDRAM programming
    output prog_addr_t  prog_addr,
    output prog_data_t  prog_data,
    output prog_mask_t  prog_mask,
    output prog_ba_t    prog_ba,
    output logic        prog_we,
    input  logic        prog_rdy,
    // Status
    output logic        dwnld_busy,
    output logic        dwnld_ovf
);

    logic fifo_empty;
    logic wr_idle_flag;

    jtframe_prog_if pack_q();
    jtframe_prog_if wr_q();

    jtframe_dwnld_pack #(
        .header     ( header      ),
        .ba1_start  ( ba1_start   ),
        .ba2_start  ( ba2_start   ),
        .ba3_start  ( ba3_start   )
    ) u_pack (
        .clk_rom    ( clk_rom     ),
        .rst_n      ( rst_n       ),
        .downloading( downloading ),
        .ioctl_addr ( ioctl_addr  ),
        .ioctl_data ( ioctl_data  ),
        .ioctl_wr   ( ioctl_wr    ),
        .q          ( pack_q      ),
        .ovf        ( dwnld_ovf   )
    );

    jtframe_prog_fifo #(
        .fifo_depth ( fifo_depth  )
    ) u_fifo (
        .clk_rom    ( clk_rom     ),
        .rst_n      ( rst_n       ),
        .wr         ( pack_q      ),
        .rd         ( wr_q        ),
        .empty      ( fifo_empty  )
    );

    jtframe_prog_wr u_wr (
        .clk_rom    ( clk_rom      ),
        .rst_n      ( rst_n        ),
        .q          ( wr_q         ),
        .prog_addr  ( prog_addr    ),
        .prog_data  ( prog_data    ),
        .prog_mask  ( prog_mask    ),
        .prog_ba    ( prog_ba      ),
        .prog_we    ( prog_we      ),
        .prog_rdy   ( prog_rdy     ),
        .idle       ( wr_idle_flag )
    );

    // Game held off until the last write is acknowledged
    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            dwnld_busy <= 1'b0;
        end else begin
            dwnld_busy <= downloading || !fifo_empty || !wr_idle_flag;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// Free-running ROM clock, reset held low for a
// fixed number of cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int period     = 40,
    parameter int rst_cycles = 8
)(
    output logic clk_rom,
    output logic rst_n
);

    initial begin
        clk_rom = 1'b0;
        forever begin
            #(period / 2) clk_rom = ~clk_rom;
        end
    end

    // Released just after a rising edge, like the other inputs
    initial begin : reset_gen
        int n;
        rst_n = 1'b0;
        for (n = 0; n < rst_cycles; n++) begin
            @(posedge clk_rom);
        end
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_romload.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM download path testbench
// Replays the trace file, answers prog_we after a
// random delay and checks every programming write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tb_romload import jtframe_romload_pkg::*; ();

    localparam int timeout = 400;

    logic            clk_rom;
    logic            rst_n;
    logic            downloading;
    ioctl_addr_t     ioctl_addr;
    ioctl_data_t     ioctl_data;
    logic            ioctl_wr;
    prog_addr_t      prog_addr;
    prog_data_t      prog_data;
    prog_mask_t      prog_mask;
    prog_ba_t        prog_ba;
    logic            prog_we;
    logic            prog_rdy;
    logic            dwnld_busy;
    logic            dwnld_ovf;

    // Expected writes packed as {ba, addr, data, mask}
    logic [41:0]     exp_q[$];
    logic [31:0]     lfsr;
    logic            rdy_stall;
    logic            we_last;
    logic            in_test;
    logic [8*24-1:0] test_name;
    int              test_errors;
    int              total_errors;
    int              pass_count;
    int              fail_count;

    tb_clkgen #(.period(40), .rst_cycles(8)) u_clkgen (.clk_rom(clk_rom), .rst_n(rst_n));

    jtframe_romload #(
        .header     ( 4      ),
        .ba1_start  ( 'h100  ),
        .ba2_start  ( 'h200  ),
        .ba3_start  ( 'h300  ),
        .fifo_depth ( 4      )
    ) jtframe_romload_inst (
        .clk_rom    ( clk_rom     ),
        .rst_n      ( rst_n       ),
        .downloading( downloading ),
        .ioctl_addr ( ioctl_addr  ),
        .ioctl_data ( ioctl_data  ),
        .ioctl_wr   ( ioctl_wr    ),
        .prog_addr  ( prog_addr   ),
        .prog_data  ( prog_data   ),
        .prog_mask  ( prog_mask   ),
        .prog_ba    ( prog_ba     ),
        .prog_we    ( prog_we     ),
        .prog_rdy   ( prog_rdy    ),
        .dwnld_busy ( dwnld_busy  ),
        .dwnld_ovf  ( dwnld_ovf   )
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_delay(output int delay);
        logic [2:0] bits;
        int         i;
        bits = '0;
        for (i = 0; i < 3; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[1:0], lfsr[0]};
        end
        // Zero maps to the shortest answer
        delay = (bits == 3'd0) ? 1 : int'(bits);
    endtask

    task automatic count_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic release_bus();
        @(posedge clk_rom);
        #1;
        ioctl_wr = 1'b0;
    endtask

    // Gap of zero keeps ioctl_wr high into the next byte
    task automatic drive_byte(input ioctl_addr_t a, input ioctl_data_t d, input int gap);
        @(posedge clk_rom);
        #1;
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        if (gap > 0) begin
            release_bus();
            repeat (gap - 1) @(posedge clk_rom);
        end
    endtask

    task automatic check_ovf(input logic v);
        int n;
        n = 0;
        while (dwnld_ovf !== v && n < 20) begin
            @(posedge clk_rom);
            #1;
            n++;
        end
        assert (dwnld_ovf === v) else begin
            $display("Error %0s: dwnld_ovf expected %0b actual %0b", test_name, v, dwnld_ovf);
            count_error();
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(posedge clk_rom);
        #1;
        while (dwnld_busy && n < timeout) begin
            @(posedge clk_rom);
            #1;
            n++;
        end
        if (dwnld_busy) begin
            $display("Timeout in %0s: dwnld_busy never fell after the download", test_name);
            count_error();
        end else begin
            assert (exp_q.size() == 0 && !prog_we) else begin
                $display("%0s: dwnld_busy fell before the last write was acknowledged",
                         test_name);
                count_error();
            end
        end
    endtask

    task automatic finish_test();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < timeout) begin
            @(posedge clk_rom);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout in %0s: %0d expected writes never reached prog_we",
                     test_name, exp_q.size());
            count_error();
            exp_q.delete();
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("%0s: passed", test_name);
        end else begin
            fail_count++;
            $display("%0s: failed with %0d errors", test_name, test_errors);
        end
        in_test = 1'b0;
    endtask

    task automatic do_line(input logic [8*128-1:0] line);
        logic [8*8-1:0] cmd;
        ioctl_addr_t    a;
        ioctl_data_t    dd;
        ioctl_data_t    bd;
        prog_ba_t       ba;
        prog_addr_t     wa;
        prog_data_t     pd;
        prog_mask_t     pm;
        int             cnt;
        int             gap;
        int             flag;
        int             fields;
        int             need;
        int             i;
        cmd    = '0;
        need   = 0;
        fields = $sscanf(line, "%s", cmd);
        if (ioctl_wr && cmd != "byte" && cmd != "run") begin
            release_bus();
        end
        case (cmd)
            "#": begin
            end
            "test": begin
                if (in_test) begin
                    finish_test();
                end
                test_name   = '0;
                need        = 2;
                fields      = $sscanf(line, "%s %s", cmd, test_name);
                in_test     = 1'b1;
                test_errors = 0;
            end
            "start", "end": begin
                @(posedge clk_rom);
                #1;
                downloading = (cmd == "start");
            end
            "byte": begin
                need   = 4;
                fields = $sscanf(line, "%s %h %h %d", cmd, a, dd, gap);
                drive_byte(a, dd, gap);
            end
            "run": begin
                need   = 5;
                fields = $sscanf(line, "%s %h %h %d %d", cmd, a, dd, cnt, gap);
                for (i = 0; i < cnt; i++) begin
                    drive_byte(a + ioctl_addr_t'(i), dd + ioctl_data_t'(i), gap);
                end
            end
            "expect": begin
                need   = 5;
                fields = $sscanf(line, "%s %h %h %h %h", cmd, ba, wa, pd, pm);
                exp_q.push_back({ba, wa, pd, pm});
            end
            "erun": begin
                need   = 5;
                fields = $sscanf(line, "%s %h %h %h %d", cmd, ba, wa, dd, cnt);
                for (i = 0; i < cnt; i++) begin
                    // Run starts on an even offset, so lanes alternate low then high
                    bd = dd + ioctl_data_t'(i);
                    exp_q.push_back({ba, wa + prog_addr_t'(i / 2), bd, bd,
                                     (i % 2 == 1) ? 2'b01 : 2'b10});
                end
            end
            "stall": begin
                need      = 2;
                fields    = $sscanf(line, "%s %d", cmd, flag);
                rdy_stall = (flag != 0);
            end
            "ovf": begin
                need   = 2;
                fields = $sscanf(line, "%s %d", cmd, flag);
                check_ovf(flag != 0);
            end
            "drain": wait_drain();
            default: begin
                $display("Unknown command in trace file: %0s", cmd);
                count_error();
            end
        endcase
        if (fields < need) begin
            $display("Trace line for command %0s has too few fields", cmd);
            count_error();
        end
    endtask

    // SDRAM controller side, one prog_rdy pulse per write
    always begin : rdy_model
        int delay;
        @(posedge clk_rom);
        #1;
        if (prog_we === 1'b1 && !rdy_stall) begin
            next_delay(delay);
            repeat (delay) @(posedge clk_rom);
            #1;
            prog_rdy = 1'b1;
            @(posedge clk_rom);
            #1;
            prog_rdy = 1'b0;
        end
    end

    // Each rise of prog_we is one new write
    always begin : write_monitor
        logic [41:0] got;
        logic [41:0] want;
        @(posedge clk_rom);
        #1;
        if (prog_we && !we_last) begin
            got = {prog_ba, prog_addr, prog_data, prog_mask};
            assert (exp_q.size() > 0) else begin
                $display("%0s: unexpected programming write to bank %0d word %06h",
                         test_name, prog_ba, prog_addr);
                count_error();
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                assert (got == want) else begin
                    $display({"Error %0s: expected ba/addr/data/mask %0d/%06h/%04h/%02b",
                              " actual %0d/%06h/%04h/%02b"}, test_name,
                             want[41:40], want[39:18], want[17:2], want[1:0],
                             got[41:40], got[39:18], got[17:2], got[1:0]);
                    count_error();
                end
            end
        end
        we_last = prog_we;
    end

    initial begin : main
        logic [8*128-1:0] line;
        int               fd;
        int               got;
        int               n;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        prog_rdy     = 1'b0;
        rdy_stall    = 1'b0;
        lfsr         = 32'h5aeb;
        we_last      = 1'b0;
        in_test      = 1'b0;
        test_name    = '0;
        test_errors  = 0;
        total_errors = 0;
        pass_count   = 0;
        fail_count   = 0;
        n = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(posedge clk_rom);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            count_error();
        end
        fd = $fopen("sim/romload_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/romload_trace.txt");
            count_error();
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                got  = $fgets(line, fd);
                // A lone newline is a blank line
                if (got > 1) begin
                    do_line(line);
                end
            end
            $fclose(fd);
        end
        if (in_test) begin
            finish_test();
        end
        if (pass_count == 0 && fail_count == 0) begin
            $display("No test was found in the trace file");
            count_error();
        end
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 pass_count, fail_count, total_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/jtframe_romload_pkg.sv
verilog/jtframe_prog_if.sv
verilog/jtframe_dwnld_pack.sv
verilog/jtframe_prog_fifo.sv
verilog/jtframe_prog_wr.sv
verilog/jtframe_romload.sv
sim/tb_clkgen.sv
sim/tb_romload.sv

// ==== sim/romload_trace.txt ====
# Columns: command then fields, addr/data/ba/mask in hex, count and gap in decimal
# byte addr data gap | run addr data0 count gap | expect ba word data mask | erun ba word data0 count
test header_skip
start
expect 0 000000 a5a5 2
run 000000 11 4 1
byte 000004 a5 3
test byte_packing
expect 0 000001 3c3c 2
expect 0 000001 c3c3 1
byte 000006 3c 3
byte 000007 c3 3
test bank_mapping
expect 0 00007f 1111 1
expect 1 000000 2222 2
expect 2 00007f 3333 2
expect 3 000000 4444 1
byte 000103 11 3
byte 000104 22 3
byte 000302 33 3
byte 000305 44 3
test burst_order
erun 3 000010 40 24
run 000324 40 24 7
ovf 0
test busy
erun 2 000040 70 3
run 000284 70 3 0
end
drain
test overflow
start
stall 1
erun 0 000006 90 5
run 000010 90 6 0
ovf 1
stall 0
end
drain
start
ovf 0
end
drain
